/* tests/valu_stimulus.txt */
// columns in hex: op cmp eew op1 op2 expected_res expected_cmp
// op 0 add 1 sub 2 saddu 3 sadd 4 ssubu 5 ssub 6 and 7 or 8 xor 9 sll a srl b sra
0 0 0 11223344556677ff 0101010101010101 1223344556677800 00
0 0 1 11223344556677ff 0101010101010101 1223344556677900 00
0 0 2 ffffffffffffffff 0000000000000001 ffffffff00000000 00
1 0 0 0510203040500000 0101010101010101 040f1f2f3f4fffff 00
1 0 1 0000010080000005 0001000100010003 ffff00ff7fff0002 00
1 0 2 1234567800000010 0234567800000011 10000000ffffffff 00
2 0 0 ff807f011020f0f0 0180800102030f20 ffffff021223ffff 00
4 0 1 00051000ffff0000 00060fff00010000 00000001fffe0000 00
3 0 0 7f804040c0c00102 01ff4040c0a0ff03 7f807f7f80800005 00
3 0 2 7ffffff090000000 0000002090000000 7fffffff80000000 00
5 0 1 80007fff0005fffe 0001ffff00070001 80007ffffffefffd 00
6 0 0 f0f0ff0012345678 ff000ff0ffff0f0f f0000f0012340608 00
7 0 0 f0f0ff0012345678 ff000ff0ffff0f0f fff0fff0ffff5f7f 00
8 0 0 f0f0ff0012345678 ff000ff0ffff0f0f 0ff0f0f0edcb5977 00
9 0 0 010101018181ffff 0001020708090f03 01020480810280f8 00
a 0 1 80008000f00f1234 000f001000040011 000180000f00091a 00
b 0 1 80008000f00f1234 000f001000040011 ffff8000ff00091a 00
b 0 0 807ff00f8101c040 07070404090102fe ff00ff00c000f001 00
b 0 2 800000007fffffff 0000003f00000024 ffffffff07ffffff 00
1 1 0 0011223344556677 0011220044550077 0000003300006600 ed
1 2 1 0011223344556677 0011220044550077 0000003300006600 33
1 3 0 01ff8000107f0500 02017f00208005ff fffe0100f0ff0001 8d
1 4 0 01ff8000107f0500 02017f00208005ff fffe0100f0ff0001 e8
1 4 2 ffffffff00000001 00000001ffffffff fffffffe00000002 f0

/* build.f */
+incdir+verilog
verilog/valu_pkg.sv
verilog/valu_pipe_ctrl.sv
verilog/valu_operand_prep.sv
verilog/valu_adder.sv
verilog/valu_shifter.sv
verilog/valu_result.sv
verilog/valu_top.sv
tests/valu_properties.sv
tests/valu_tb.sv

/* Bender.yml */
package:
  name: valu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/valu_pkg.sv
      - verilog/valu_pipe_ctrl.sv
      - verilog/valu_operand_prep.sv
      - verilog/valu_adder.sv
      - verilog/valu_shifter.sv
      - verilog/valu_result.sv
      - verilog/valu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/valu_properties.sv
      - tests/valu_tb.sv

/* tests/valu_tb.sv */
/*
 * testbench for the packed-SIMD ALU
 * streams vectors from the stimulus file and checks results in order
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_tb import valu_pkg::*;;

    // one strobe plus at most two idle cycles per vector
    localparam int MAX_GAP = 2;

    logic        clk_i;
    logic        async_rst_ni;
    logic        valid_i;
    alu_op_e     op_i;
    cmp_op_e     cmp_i;
    eew_e        eew_i;
    op_word_t    op1_i;
    op_word_t    op2_i;
    logic        valid_o;
    op_word_t    res_o;
    byte_flags_t cmp_o;

    alu_op_e     vec_op[$];
    cmp_op_e     vec_cmp[$];
    eew_e        vec_eew[$];
    op_word_t    vec_op1[$];
    op_word_t    vec_op2[$];
    op_word_t    vec_res[$];
    byte_flags_t vec_flags[$];
    int          issue_idx_q[$];
    int          issue_cycle_q[$];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          checked_count = 0;

    valu_top dut (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .cmp_i        (cmp_i),
        .eew_i        (eew_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .valid_o      (valid_o),
        .res_o        (res_o),
        .cmp_o        (cmp_o)
    );

    bind valu_top valu_properties u_props (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (valid_i),
        .out_valid_i  (valid_o),
        .res_i        (res_o),
        .flags_i      (cmp_o)
    );

    always #10 clk_i = ~clk_i;

    ////////////////////////////////////////
    // checking

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_output();
        int    idx;
        int    issued;
        string name;
        if (issue_idx_q.size() == 0) begin
            $display("output strobe seen while no operation was in flight");
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first error");
        end else begin
            idx    = issue_idx_q.pop_front();
            issued = issue_cycle_q.pop_front();
            name   = $sformatf("vector %0d (%s)", idx, vec_op[idx].name());
            check_value({name, " res"}, vec_res[idx], res_o);
            check_value({name, " cmp"}, 64'(vec_flags[idx]), 64'(cmp_o));
            check_value({name, " latency"}, 64'(`VALU_LATENCY), 64'(cycle_count - issued));
            checked_count++;
        end
    endtask

    // outputs are read at the falling edge, half a cycle after they settle
    always @(negedge clk_i) begin
        if (valid_o) begin
            check_output();
        end
        if (dut.u_props.error_count != 0) begin
            $display("a bound assertion on the DUT failed");
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first error");
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with results still missing", cycle_count);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping on timeout");
        end
    end

    ////////////////////////////////////////
    // stimulus

    task automatic load_vectors();
        int         fd;
        int         count;
        string      line;
        logic [3:0] f_op;
        logic [2:0] f_cmp;
        logic [1:0] f_eew;
        op_word_t   f_op1;
        op_word_t   f_op2;
        op_word_t   f_res;
        logic [7:0] f_flags;
        fd = $fopen("tests/valu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/valu_stimulus.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first error");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "/") begin
                count = $sscanf(line, "%h %h %h %h %h %h %h",
                                f_op, f_cmp, f_eew, f_op1, f_op2, f_res, f_flags);
                if (count != 7) begin
                    $display("malformed line in the stimulus file: %s", line);
                    $display("Simulation finished: FAIL");
                    $fatal(1, "stopping at the first error");
                end
                vec_op.push_back(alu_op_e'(f_op));
                vec_cmp.push_back(cmp_op_e'(f_cmp));
                vec_eew.push_back(eew_e'(f_eew));
                vec_op1.push_back(f_op1);
                vec_op2.push_back(f_op2);
                vec_res.push_back(f_res);
                vec_flags.push_back(f_flags);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int gap;
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        valid_i      = 1'b0;
        op_i         = ALU_ADD;
        cmp_i        = CMP_NONE;
        eew_i        = EEW_8;
        op1_i        = '0;
        op2_i        = '0;
        void'($urandom(21));
        load_vectors();
        cycle_limit = vec_op.size() * (MAX_GAP + 1) + 40;

        repeat (3) @(posedge clk_i);
        async_rst_ni <= 1'b1;

        for (int i = 0; i < vec_op.size(); i++) begin
            // the first few go back to back, the rest get random idle gaps
            gap = (i < 4) ? 0 : int'($urandom % (MAX_GAP + 1));
            repeat (gap) begin
                @(posedge clk_i);
                valid_i <= 1'b0;
            end
            @(posedge clk_i);
            valid_i <= 1'b1;
            op_i    <= vec_op[i];
            cmp_i   <= vec_cmp[i];
            eew_i   <= vec_eew[i];
            op1_i   <= vec_op1[i];
            op2_i   <= vec_op2[i];
            issue_idx_q.push_back(i);
            // counter value once this edge has passed
            issue_cycle_q.push_back(cycle_count + 1);
        end
        @(posedge clk_i);
        valid_i <= 1'b0;

        wait (checked_count == vec_op.size());
        repeat (`VALU_LATENCY + 2) @(posedge clk_i);
        if (dut.u_props.error_count != 0) begin
            $display("a bound assertion on the DUT failed at the end of the run");
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* tests/valu_properties.sv */
/*
 * timing and output checks for the packed-SIMD ALU, bound into the top level
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_properties import valu_pkg::*; (
    input logic        clk_i,
    input logic        async_rst_ni,
    input logic        in_valid_i,
    input logic        out_valid_i,
    input op_word_t    res_i,
    input byte_flags_t flags_i
);

    // read by the testbench so that a failed property ends the run
    int unsigned error_count = 0;

    // every accepted strobe comes out exactly the pipeline depth later
    a_latency: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        in_valid_i |-> ##(`VALU_LATENCY) out_valid_i)
    else begin
        error_count++;
        $error("output strobe missing after an accepted input strobe");
    end

    a_no_spurious: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i |-> $past(in_valid_i, `VALU_LATENCY))
    else begin
        error_count++;
        $error("output strobe without a matching input strobe");
    end

    a_reset_low: assert property (@(posedge clk_i) !async_rst_ni |=> !out_valid_i)
    else begin
        error_count++;
        $error("output strobe high after reset");
    end

    a_quiet: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !out_valid_i |-> (res_i == '0) && (flags_i == '0))
    else begin
        error_count++;
        $error("result or flags nonzero while the output strobe is low");
    end

endmodule

/* verilog/valu_top.sv */
/*
 * packed-SIMD integer ALU top level
 * three-stage pipeline, one strobe in and one strobe out per operation
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_top import valu_pkg::*; (
    input  logic        clk_i,
    input  logic        async_rst_ni,
    input  logic        valid_i,
    input  alu_op_e     op_i,
    input  cmp_op_e     cmp_i,
    input  eew_e        eew_i,
    input  op_word_t    op1_i,
    input  op_word_t    op2_i,
    output logic        valid_o,
    output op_word_t    res_o,
    output byte_flags_t cmp_o
);

    logic        s1_valid;
    logic        s2_valid;
    logic        s3_valid;
    alu_op_e     s1_op;
    eew_e        s1_eew;
    alu_op_e     s2_op;
    cmp_op_e     s2_cmp;
    eew_e        s2_eew;
    adder_word_t opa;
    adder_word_t opb;
    op_word_t    op1_s1;
    op_word_t    op2_s1;
    op_word_t    sum;
    byte_flags_t carry;
    byte_flags_t ovflw;
    byte_flags_t sign;
    satval_t     satval;
    op_word_t    bitwise;

    // the stage tree below holds exactly three register stages
    if (`VALU_LATENCY != 3) begin : g_latency_check
        $error("valu_top: stage tree has three registers, VALU_LATENCY differs");
    end

    valu_pipe_ctrl u_pipe_ctrl (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .cmp_i        (cmp_i),
        .eew_i        (eew_i),
        .s1_valid_o   (s1_valid),
        .s2_valid_o   (s2_valid),
        .s3_valid_o   (s3_valid),
        .s1_op_o      (s1_op),
        .s1_eew_o     (s1_eew),
        .s2_op_o      (s2_op),
        .s2_cmp_o     (s2_cmp),
        .s2_eew_o     (s2_eew)
    );

    valu_operand_prep u_operand_prep (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .eew_i        (eew_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .opa_o        (opa),
        .opb_o        (opb),
        .op1_o        (op1_s1),
        .op2_o        (op2_s1)
    );

    valu_adder u_adder (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .s1_valid_i   (s1_valid),
        .s1_op_i      (s1_op),
        .s1_eew_i     (s1_eew),
        .opa_i        (opa),
        .opb_i        (opb),
        .sum_o        (sum),
        .carry_o      (carry),
        .ovflw_o      (ovflw),
        .sign_o       (sign),
        .satval_o     (satval)
    );

    valu_shifter u_shifter (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .s1_valid_i   (s1_valid),
        .s1_op_i      (s1_op),
        .s1_eew_i     (s1_eew),
        .op1_i        (op1_s1),
        .op2_i        (op2_s1),
        .bitwise_o    (bitwise)
    );

    valu_result u_result (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .s2_valid_i   (s2_valid),
        .s2_op_i      (s2_op),
        .s2_cmp_i     (s2_cmp),
        .s2_eew_i     (s2_eew),
        .sum_i        (sum),
        .carry_i      (carry),
        .ovflw_i      (ovflw),
        .sign_i       (sign),
        .satval_i     (satval),
        .bitwise_i    (bitwise),
        .res_o        (res_o),
        .cmp_o        (cmp_o)
    );

    assign valid_o = s3_valid;

endmodule

/* verilog/valu_result.sv */
/*
 * result stage
 * picks sum, saturated sum or logic word, forms compare flags, output register
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_result import valu_pkg::*; (
    input  logic        clk_i,
    input  logic        async_rst_ni,
    input  logic        s2_valid_i,
    input  alu_op_e     s2_op_i,
    input  cmp_op_e     s2_cmp_i,
    input  eew_e        s2_eew_i,
    input  op_word_t    sum_i,
    input  byte_flags_t carry_i,
    input  byte_flags_t ovflw_i,
    input  byte_flags_t sign_i,
    input  satval_t     satval_i,
    input  op_word_t    bitwise_i,
    output op_word_t    res_o,
    output byte_flags_t cmp_o
);

    byte_flags_t byte_zero;
    byte_flags_t elem_zero;
    byte_flags_t sat_sel;
    op_word_t    res_d;
    byte_flags_t cmp_d;

    ////////////////////////////////////////
    // arithmetic and logic result

    // signed ops clamp on overflow, unsigned ones on carry or borrow
    always_comb begin
        case (s2_op_i)
            ALU_SADD, ALU_SSUB:   sat_sel = ovflw_i;
            ALU_SADDU, ALU_SSUBU: sat_sel = carry_i;
            default:              sat_sel = '0;
        endcase
    end

    always_comb begin
        res_d = '0;
        case (s2_op_i)
            ALU_ADD, ALU_SUB: res_d = sum_i;
            ALU_SADDU, ALU_SADD, ALU_SSUBU, ALU_SSUB: begin
                for (int i = 0; i < `VALU_BYTES; i++) begin
                    res_d[8*i +: 8] = sat_sel[i] ? {satval_i[2*i+1], {7{satval_i[2*i]}}}
                                                 : sum_i[8*i +: 8];
                end
            end
            default: res_d = bitwise_i;
        endcase
    end

    ////////////////////////////////////////
    // compare flags

    always_comb begin
        for (int i = 0; i < `VALU_BYTES; i++) begin
            byte_zero[i] = (sum_i[8*i +: 8] == 8'h00);
        end
        // an element is zero when every byte that shares its start is zero
        for (int i = 0; i < `VALU_BYTES; i++) begin
            elem_zero[i] = 1'b1;
            for (int j = 0; j < `VALU_BYTES; j++) begin
                if (elem_lo(j, s2_eew_i) == elem_lo(i, s2_eew_i)) begin
                    elem_zero[i] = elem_zero[i] & byte_zero[j];
                end
            end
        end
    end

    always_comb begin
        case (s2_cmp_i)
            CMP_EQ:  cmp_d = elem_zero;
            CMP_NE:  cmp_d = ~elem_zero;
            CMP_LTU: cmp_d = carry_i;
            CMP_LT:  cmp_d = ovflw_i ^ sign_i;
            default: cmp_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_o <= '0;
            cmp_o <= '0;
        end else if (s2_valid_i) begin
            res_o <= res_d;
            cmp_o <= cmp_d;
        end else begin
            res_o <= '0;
            cmp_o <= '0;
        end
    end

endmodule

/* verilog/valu_shifter.sv */
/*
 * shift and logic stage
 * per-element barrel shifts and bitwise operations, registered at stage two
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_shifter import valu_pkg::*; (
    input  logic     clk_i,
    input  logic     async_rst_ni,
    input  logic     s1_valid_i,
    input  alu_op_e  s1_op_i,
    input  eew_e     s1_eew_i,
    input  op_word_t op1_i,
    input  op_word_t op2_i,
    output op_word_t bitwise_o
);

    logic     arith;
    op_word_t shl;
    op_word_t shr;
    op_word_t bitwise_d;

    assign arith = (s1_op_i == ALU_SRA);

    // right shifts go through one extra fill bit above the element msb
    always_comb begin : shift_comb
        logic [8:0]  t8;
        logic [16:0] t16;
        logic [32:0] t32;
        shl = '0;
        shr = '0;
        case (s1_eew_i)
            EEW_8: begin
                for (int i = 0; i < `VALU_BYTES; i++) begin
                    shl[8*i +: 8] = op1_i[8*i +: 8] << op2_i[8*i +: 3];
                    t8 = $signed({arith & op1_i[8*i+7], op1_i[8*i +: 8]}) >>> op2_i[8*i +: 3];
                    shr[8*i +: 8] = t8[7:0];
                end
            end
            EEW_16: begin
                for (int i = 0; i < `VALU_BYTES/2; i++) begin
                    shl[16*i +: 16] = op1_i[16*i +: 16] << op2_i[16*i +: 4];
                    t16 = $signed({arith & op1_i[16*i+15], op1_i[16*i +: 16]})
                          >>> op2_i[16*i +: 4];
                    shr[16*i +: 16] = t16[15:0];
                end
            end
            EEW_32: begin
                for (int i = 0; i < `VALU_BYTES/4; i++) begin
                    shl[32*i +: 32] = op1_i[32*i +: 32] << op2_i[32*i +: 5];
                    t32 = $signed({arith & op1_i[32*i+31], op1_i[32*i +: 32]})
                          >>> op2_i[32*i +: 5];
                    shr[32*i +: 32] = t32[31:0];
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (s1_op_i)
            ALU_AND:          bitwise_d = op1_i & op2_i;
            ALU_OR:           bitwise_d = op1_i | op2_i;
            ALU_XOR:          bitwise_d = op1_i ^ op2_i;
            ALU_SLL:          bitwise_d = shl;
            ALU_SRL, ALU_SRA: bitwise_d = shr;
            default:          bitwise_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            bitwise_o <= '0;
        end else if (s1_valid_i) begin
            bitwise_o <= bitwise_d;
        end
    end

endmodule

/* verilog/valu_adder.sv */
/*
 * fracturable adder stage
 * lane sums with per-element carry, sign, overflow and saturation values
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_adder import valu_pkg::*; (
    input  logic        clk_i,
    input  logic        async_rst_ni,
    input  logic        s1_valid_i,
    input  alu_op_e     s1_op_i,
    input  eew_e        s1_eew_i,
    input  adder_word_t opa_i,
    input  adder_word_t opb_i,
    output op_word_t    sum_o,
    output byte_flags_t carry_o,
    output byte_flags_t ovflw_o,
    output byte_flags_t sign_o,
    output satval_t     satval_o
);

    logic [36:0] lane_sum [`VALU_LANES];
    logic        subtract;
    logic        signed_sat;
    op_word_t    sum_d;
    byte_flags_t carry_d;
    byte_flags_t ovflw_d;
    byte_flags_t sign_d;
    satval_t     satval_d;

    assign subtract   = is_subtract(s1_op_i);
    assign signed_sat = (s1_op_i == ALU_SADD) || (s1_op_i == ALU_SSUB);

    // one 37-bit add per lane, the top bit catches the carry of the last byte
    always_comb begin
        for (int l = 0; l < `VALU_LANES; l++) begin
            lane_sum[l] = {1'b0, opa_i[36*l +: 36]} + {1'b0, opb_i[36*l +: 36]};
        end
    end

    ////////////////////////////////////////
    // per-element flags

    always_comb begin : flag_comb
        int unsigned hi;
        int unsigned lane;
        int unsigned top;
        logic        raw_carry;
        logic        sign_a;
        logic        sign_b;
        logic        sign_r;
        for (int i = 0; i < `VALU_BYTES; i++) begin
            hi   = elem_hi(i, s1_eew_i);
            lane = hi / 4;
            top  = hi % 4;
            sum_d[8*i +: 8] = lane_sum[i/4][9*(i%4)+1 +: 8];
            // the carry of an element lands on the break bit above its top byte
            raw_carry = lane_sum[lane][9*(top+1)];
            sign_r    = lane_sum[lane][9*top+8];
            sign_a    = opa_i[9*hi+8];
            sign_b    = opb_i[9*hi+8];
            carry_d[i] = raw_carry ^ subtract;
            sign_d[i]  = sign_r;
            // op2 is already inverted for subtract, so the add rule holds
            ovflw_d[i] = ~(sign_a ^ sign_b) & (sign_a ^ sign_r);
            if (signed_sat) begin
                satval_d[2*i+1] = (i == hi) ? ~sign_r : sign_r;
                satval_d[2*i]   = sign_r;
            end else begin
                // all ones after an add carry, all zeros after a borrow
                satval_d[2*i +: 2] = {2{raw_carry}};
            end
        end
    end

    ////////////////////////////////////////
    // stage two registers

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            sum_o    <= '0;
            carry_o  <= '0;
            ovflw_o  <= '0;
            sign_o   <= '0;
            satval_o <= '0;
        end else if (s1_valid_i) begin
            sum_o    <= sum_d;
            carry_o  <= carry_d;
            ovflw_o  <= ovflw_d;
            sign_o   <= sign_d;
            satval_o <= satval_d;
        end
    end

endmodule

/* verilog/valu_operand_prep.sv */
/*
 * operand preparation stage
 * spreads operands into the carry-break adder layout and registers stage one
 */
`timescale 1ns/1ps
`include "valu_settings.svh"

module valu_operand_prep import valu_pkg::*; (
    input  logic        clk_i,
    input  logic        async_rst_ni,
    input  logic        valid_i,
    input  alu_op_e     op_i,
    input  eew_e        eew_i,
    input  op_word_t    op1_i,
    input  op_word_t    op2_i,
    output adder_word_t opa_o,
    output adder_word_t opb_o,
    output op_word_t    op1_o,
    output op_word_t    op2_o
);

    logic        subtract;
    adder_word_t opa_d;
    adder_word_t opb_d;
    adder_word_t opa_q;
    adder_word_t opb_q;
    op_word_t    op1_q;
    op_word_t    op2_q;

    assign subtract = is_subtract(op_i);

    ////////////////////////////////////////
    // adder operand layout

    always_comb begin
        for (int i = 0; i < `VALU_BYTES; i++) begin
            opa_d[9*i+1 +: 8] = op1_i[8*i +: 8];
            opb_d[9*i+1 +: 8] = subtract ? ~op2_i[8*i +: 8] : op2_i[8*i +: 8];
            if (elem_lo(i, eew_i) == i) begin
                // both bits equal the carry-in, so the chain from below is cut
                opa_d[9*i] = subtract;
                opb_d[9*i] = subtract;
            end else begin
                // one and zero pass the carry of the lower byte straight on
                opa_d[9*i] = 1'b1;
                opb_d[9*i] = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // stage one registers

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            opa_q <= '0;
            opb_q <= '0;
            op1_q <= '0;
            op2_q <= '0;
        end else if (valid_i) begin
            opa_q <= opa_d;
            opb_q <= opb_d;
            op1_q <= op1_i;
            op2_q <= op2_i;
        end
    end

    assign opa_o = opa_q;
    assign opb_o = opb_q;
    assign op1_o = op1_q;
    assign op2_o = op2_q;

endmodule

/* verilog/valu_pipe_ctrl.sv */
/*
 * control pipeline of the packed-SIMD ALU
 * carries the strobe and the operation fields alongside the data stages
 */
`timescale 1ns/1ps

module valu_pipe_ctrl import valu_pkg::*; (
    input  logic    clk_i,
    input  logic    async_rst_ni,
    input  logic    valid_i,
    input  alu_op_e op_i,
    input  cmp_op_e cmp_i,
    input  eew_e    eew_i,
    output logic    s1_valid_o,
    output logic    s2_valid_o,
    output logic    s3_valid_o,
    output alu_op_e s1_op_o,
    output eew_e    s1_eew_o,
    output alu_op_e s2_op_o,
    output cmp_op_e s2_cmp_o,
    output eew_e    s2_eew_o
);

    logic    s1_valid_q;
    logic    s2_valid_q;
    logic    s3_valid_q;
    alu_op_e s1_op_q;
    cmp_op_e s1_cmp_q;
    eew_e    s1_eew_q;
    alu_op_e s2_op_q;
    cmp_op_e s2_cmp_q;
    eew_e    s2_eew_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            s3_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= valid_i;
            s2_valid_q <= s1_valid_q;
            s3_valid_q <= s2_valid_q;
        end
    end

    // each stage keeps the control of the item it currently holds
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            s1_op_q  <= op_i;
            s1_cmp_q <= cmp_i;
            s1_eew_q <= eew_i;
        end
        if (s1_valid_q) begin
            s2_op_q  <= s1_op_q;
            s2_cmp_q <= s1_cmp_q;
            s2_eew_q <= s1_eew_q;
        end
    end

    assign s1_valid_o = s1_valid_q;
    assign s2_valid_o = s2_valid_q;
    assign s3_valid_o = s3_valid_q;
    assign s1_op_o    = s1_op_q;
    assign s1_eew_o   = s1_eew_q;
    assign s2_op_o    = s2_op_q;
    assign s2_cmp_o   = s2_cmp_q;
    assign s2_eew_o   = s2_eew_q;

endmodule

/* verilog/valu_pkg.sv */
/*
 * packed-SIMD ALU types
 * data word typedefs, operation enums and element boundary helpers
 */
`include "valu_settings.svh"

package valu_pkg;

    typedef logic [`VALU_OP_W-1:0]    op_word_t;
    typedef logic [`VALU_BYTES-1:0]   byte_flags_t;
    // nine bits per byte, bit 0 of each byte slot is the carry-break position
    typedef logic [`VALU_BYTES*9-1:0] adder_word_t;
    // per byte a sign bit (upper) and a fill bit (lower)
    typedef logic [`VALU_BYTES*2-1:0] satval_t;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SADDU = 4'd2,
        ALU_SADD  = 4'd3,
        ALU_SSUBU = 4'd4,
        ALU_SSUB  = 4'd5,
        ALU_AND   = 4'd6,
        ALU_OR    = 4'd7,
        ALU_XOR   = 4'd8,
        ALU_SLL   = 4'd9,
        ALU_SRL   = 4'd10,
        ALU_SRA   = 4'd11
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NONE = 3'd0,
        CMP_EQ   = 3'd1,
        CMP_NE   = 3'd2,
        CMP_LTU  = 3'd3,
        CMP_LT   = 3'd4
    } cmp_op_e;

    // the subtract family inverts op2 and injects a carry at each element start
    function automatic logic is_subtract(alu_op_e op);
        return (op == ALU_SUB) || (op == ALU_SSUBU) || (op == ALU_SSUB);
    endfunction

    function automatic int unsigned elem_bytes(eew_e eew);
        case (eew)
            EEW_16:  return 2;
            EEW_32:  return 4;
            default: return 1;
        endcase
    endfunction

    // first and last byte index of the element that holds byte b
    function automatic int unsigned elem_lo(int unsigned b, eew_e eew);
        return b & ~(elem_bytes(eew) - 1);
    endfunction

    function automatic int unsigned elem_hi(int unsigned b, eew_e eew);
        return elem_lo(b, eew) + elem_bytes(eew) - 1;
    endfunction

endpackage

/* verilog/valu_settings.svh */
/*
 * packed-SIMD ALU global sizes
 * word width, byte count, adder lanes and pipeline depth
 */
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// operand and result word width in bits
`define VALU_OP_W 64

// bytes per word, one flag bit each
`define VALU_BYTES 8

// independent 32-bit adder lanes
`define VALU_LANES 2

// register stages from input strobe to output strobe
`define VALU_LATENCY 3

`endif
